//--- src/accumGeomPkg.sv
package accumGeomPkg;

	// Bits handled by one carry-save slice.
	localparam int SliceWidth = 2;

	// Slices in the accumulator.
	// Slice 0 holds the least significant bits.
	localparam int SliceCount = 21;

	// Full accumulator width.
	localparam int AccWidth = SliceWidth * SliceCount;

	// Phase bits sent out of the design.
	// Taken from the top of the accumulator.
	localparam int PhaseWidth = 10;

	// Top slices whose sums form the phase output.
	localparam int OutSlices = PhaseWidth / SliceWidth;

	// Edges from the tuning register to the phase output.
	// One per slice through the skew, plus the output register.
	localparam int PipeLatency = SliceCount + 1;

endpackage

//--- src/accumTypesPkg.sv
package accumTypesPkg;

	import accumGeomPkg::*;

	// Tuning interface at the top level.
	// Word and enable are taken only when load is high.
	typedef struct packed
	{
		logic load;
		logic enable;
		logic [AccWidth-1:0] word;
	} tuneCfg_t;

	// One slice's share of an addition.
	// The enable rides along so a pause stays aligned with its word.
	typedef struct packed
	{
		logic enable;
		logic [SliceWidth-1:0] addend;
	} sliceLane_t;

	// Output sample of the accumulator.
	// Wrap marks the cycle where the addition overflowed.
	typedef struct packed
	{
		logic [PhaseWidth-1:0] phase;
		logic wrap;
	} phaseSample_t;

endpackage

//--- src/tuningWordReg.sv
`timescale 1ns/1ps

module tuningWordReg
(
	input logic Clock,
	input logic reset,
	input accumTypesPkg::tuneCfg_t cfg,
	output logic [accumGeomPkg::AccWidth-1:0] word,
	output logic enable
);

	// Holds the frequency word between load strobes.
	// The accumulator adds it once per enabled cycle.
	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			word <= '0;
		end
		else if (cfg.load)
		begin
			word <= cfg.word;
		end
	end

	// Enable is kept in its own register.
	// Clearing it pauses the accumulator without losing the word.
	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			enable <= 1'b0;
		end
		else if (cfg.load)
		begin
			enable <= cfg.enable;
		end
	end

	// A strobe is never refused, so a new word may arrive every cycle.
	// Words already inside the skew finish with their own enable.

endmodule

//--- src/laneSkew.sv
`timescale 1ns/1ps

module laneSkew
(
	input logic Clock,
	input logic reset,
	input logic [accumGeomPkg::AccWidth-1:0] word,
	input logic enable,
	output accumTypesPkg::sliceLane_t lanes [accumGeomPkg::SliceCount]
);

	import accumGeomPkg::*;
	import accumTypesPkg::*;

	// Triangular input skew.
	// Lane k reaches its slice k cycles after lane 0.
	// This gives each carry one cycle to travel to the next slice.
	for (genvar k = 0; k < SliceCount; k++)
	begin : genLane

		sliceLane_t laneIn;

		// Cut the word into slice-sized addends.
		assign laneIn.enable = enable;
		assign laneIn.addend = word[k*SliceWidth +: SliceWidth];

		if (k == 0)
		begin : genDirect
			// The lowest slice sees the held word at once.
			assign lanes[k] = laneIn;
		end
		else
		begin : genDelay

			sliceLane_t stages [k];

			// Delay chain of depth k.
			// Cleared on reset so no stale enable reaches a slice.
			always_ff @(posedge Clock)
			begin
				if (reset)
				begin
					for (int i = 0; i < k; i++)
					begin
						stages[i] <= '0;
					end
				end
				else
				begin
					stages[0] <= laneIn;
					for (int i = 1; i < k; i++)
					begin
						stages[i] <= stages[i-1];
					end
				end
			end

			// Oldest entry feeds the slice.
			assign lanes[k] = stages[k-1];

		end

	end

endmodule

//--- src/sliceCarryChain.sv
`timescale 1ns/1ps

module sliceCarryChain
(
	input logic Clock,
	input logic reset,
	input accumTypesPkg::sliceLane_t lanes [accumGeomPkg::SliceCount],
	output logic [accumGeomPkg::OutSlices-1:0][accumGeomPkg::SliceWidth-1:0] topSums,
	output logic topCarry
);

	import accumGeomPkg::*;

	// Sum and carry registers of every slice.
	logic [SliceWidth-1:0] sums [SliceCount];
	logic carries [SliceCount];

	for (genvar k = 0; k < SliceCount; k++)
	begin : genSlice

		logic [SliceWidth-1:0] sumReg;
		logic carryReg;
		logic carryIn;
		logic [SliceWidth:0] total;

		// Slice 0 starts the chain.
		// Every other slice takes the registered carry from below.
		if (k == 0)
		begin : genFirst
			assign carryIn = 1'b0;
		end
		else
		begin : genNext
			assign carryIn = carries[k-1];
		end

		// Widened so the carry out of the slice is kept.
		assign total = {1'b0, sumReg} + {1'b0, lanes[k].addend} + carryIn;

		// Accumulate only on an enabled slot.
		// A paused slot holds the sum and sends no carry upward.
		always_ff @(posedge Clock)
		begin
			if (reset)
			begin
				sumReg <= '0;
				carryReg <= 1'b0;
			end
			else if (lanes[k].enable)
			begin
				sumReg <= total[SliceWidth-1:0];
				carryReg <= total[SliceWidth];
			end
			else
			begin
				carryReg <= 1'b0;
			end
		end

		assign sums[k] = sumReg;
		assign carries[k] = carryReg;

	end

	// Only the top slices leave the design.
	// The lower sums stay here as accumulator state.
	always_comb
	begin
		for (int j = 0; j < OutSlices; j++)
		begin
			topSums[j] = sums[SliceCount-OutSlices+j];
		end
	end

	// Carry out of the last slice marks an overflow.
	assign topCarry = carries[SliceCount-1];

endmodule

//--- src/sumDeskew.sv
`timescale 1ns/1ps

module sumDeskew
(
	input logic Clock,
	input logic reset,
	input logic [accumGeomPkg::OutSlices-1:0][accumGeomPkg::SliceWidth-1:0] topSums,
	input logic topCarry,
	output accumTypesPkg::phaseSample_t phase
);

	import accumGeomPkg::*;

	// Top sums after realignment to the last slice.
	logic [SliceWidth-1:0] alignedSums [OutSlices];

	// Output deskew.
	// Lower top slices finish earlier and wait for the last one.
	for (genvar j = 0; j < OutSlices; j++)
	begin : genAlign

		// Slice index SliceCount-OutSlices+j waits SliceCount-1 minus that index.
		localparam int Depth = OutSlices - 1 - j;

		if (Depth == 0)
		begin : genDirect
			// The last slice is already aligned.
			assign alignedSums[j] = topSums[j];
		end
		else
		begin : genDelay

			logic [SliceWidth-1:0] chain [Depth];

			always_ff @(posedge Clock)
			begin
				if (reset)
				begin
					for (int i = 0; i < Depth; i++)
					begin
						chain[i] <= '0;
					end
				end
				else
				begin
					chain[0] <= topSums[j];
					for (int i = 1; i < Depth; i++)
					begin
						chain[i] <= chain[i-1];
					end
				end
			end

			assign alignedSums[j] = chain[Depth-1];

		end

	end

	// Final output register.
	// The top carry comes from the last slice, so it needs no delay.
	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			phase <= '0;
		end
		else
		begin
			phase.wrap <= topCarry;
			for (int j = 0; j < OutSlices; j++)
			begin
				phase.phase[j*SliceWidth +: SliceWidth] <= alignedSums[j];
			end
		end
	end

endmodule

//--- src/phaseAccumTop.sv
`timescale 1ns/1ps

module phaseAccumTop
(
	input logic Clock,
	input logic reset,
	input accumTypesPkg::tuneCfg_t cfg,
	output accumTypesPkg::phaseSample_t phase
);

	import accumGeomPkg::*;
	import accumTypesPkg::*;

	// Tuning register outputs.
	logic [AccWidth-1:0] heldWord;
	logic heldEnable;

	// Skewed addends, one lane per slice.
	sliceLane_t lanes [SliceCount];

	// Top sums and overflow leaving the carry chain.
	logic [OutSlices-1:0][SliceWidth-1:0] topSums;
	logic topCarry;

	// Frequency word and enable.
	tuningWordReg tuningReg
	(
		.Clock(Clock),
		.reset(reset),
		.cfg(cfg),
		.word(heldWord),
		.enable(heldEnable)
	);

	// Input skew.
	laneSkew skew
	(
		.Clock(Clock),
		.reset(reset),
		.word(heldWord),
		.enable(heldEnable),
		.lanes(lanes)
	);

	// Pipelined accumulator.
	sliceCarryChain carryChain
	(
		.Clock(Clock),
		.reset(reset),
		.lanes(lanes),
		.topSums(topSums),
		.topCarry(topCarry)
	);

	// Output realignment and register.
	sumDeskew deskew
	(
		.Clock(Clock),
		.reset(reset),
		.topSums(topSums),
		.topCarry(topCarry),
		.phase(phase)
	);

endmodule

//--- test/phaseAccum_checker.sv
`timescale 1ns/1ps

module phaseAccumChecker
(
	input logic Clock,
	input logic reset,
	input accumTypesPkg::phaseSample_t phase,
	input logic heldEnable
);

	import accumGeomPkg::*;

	// Number of failed properties so far.
	int failCount = 0;

	// Reset clears the output register at the same edge.
	assert property (@(posedge Clock) reset |=> (phase == '0))
		else
		begin
			failCount++;
			$error("Phase output not cleared by reset.");
		end

	assert property (@(posedge Clock) disable iff (reset) !$isunknown(phase.wrap))
		else
		begin
			failCount++;
			$error("Wrap flag is unknown.");
		end

	// Once the held enable has been low through the whole pipeline, no addition is in flight.
	assert property (@(posedge Clock) disable iff (reset)
		!heldEnable [*PipeLatency+1] |=> $stable(phase.phase))
		else
		begin
			failCount++;
			$error("Phase moved while the accumulator was paused.");
		end

endmodule

bind phaseAccumTop phaseAccumChecker accumChecker
(
	.Clock(Clock),
	.reset(reset),
	.phase(phase),
	.heldEnable(heldEnable)
);

//--- test/phaseAccumTb.sv
`timescale 1ns/1ps

module phaseAccumTb;

	import accumGeomPkg::*;
	import accumTypesPkg::*;

	localparam int ClockPeriod = 100;
	localparam int ResetCycles = 4;
	localparam int NumRows = 8;

	// One table row: word, enable, cycles to hold it, and whether to draw random words.
	typedef struct packed
	{
		logic [AccWidth-1:0] word;
		logic enable;
		logic [15:0] holdCycles;
		logic randomWord;
	} stimRow_t;

	logic Clock;
	logic reset;
	tuneCfg_t cfg;
	phaseSample_t phase;

	// Idle, slow ramp, wrap on most steps, freeze, resume, random words, drain.
	stimRow_t stimTable [NumRows] = '{
		'{42'h000_0000_0000, 1'b0, 16'd6, 1'b0},
		'{42'h001_5555_5555, 1'b1, 16'd60, 1'b0},
		'{42'h3FF_FFFF_FFFF, 1'b1, 16'd12, 1'b0},
		'{42'h2AA_AAAA_AAAB, 1'b1, 16'd40, 1'b0},
		'{42'h0C3_1234_5678, 1'b0, 16'd40, 1'b0},
		'{42'h0C3_1234_5678, 1'b1, 16'd30, 1'b0},
		'{42'h000_0000_0000, 1'b1, 16'd80, 1'b1},
		'{42'h000_0000_0000, 1'b0, 16'd30, 1'b0}
	};

	// Reference model state.
	logic [AccWidth-1:0] modelWord;
	logic modelEnable;
	logic [AccWidth-1:0] modelAcc;
	phaseSample_t history [PipeLatency];

	logic [31:0] lfsrState;
	int cycleCount;
	int cycleLimit;

	phaseAccumTop phaseAccumTop_inst
	(
		.Clock(Clock),
		.reset(reset),
		.cfg(cfg),
		.phase(phase)
	);

	always #(ClockPeriod / 2) Clock = ~Clock;

	// Fibonacci LFSR, polynomial x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic drawRandomWord(output logic [AccWidth-1:0] value);
		for (int i = 0; i < AccWidth; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			value[i] = lfsrState[0];
		end
	endtask

	task automatic checkEqual(input logic [AccWidth-1:0] actual,
		input logic [AccWidth-1:0] expected, input string what);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "Stopping at the first mismatch.");
		end
	endtask

	// One clock edge of the model.
	// The addition is booked at the edge where the register takes the word.
	task automatic advanceModel(input logic load, input logic en,
		input logic [AccWidth-1:0] value, output phaseSample_t expected);
		logic [AccWidth:0] total;
		phaseSample_t newest;
		if (load)
		begin
			modelWord = value;
			modelEnable = en;
		end
		newest.wrap = 1'b0;
		if (modelEnable)
		begin
			total = {1'b0, modelAcc} + {1'b0, modelWord};
			modelAcc = total[AccWidth-1:0];
			newest.wrap = total[AccWidth];
		end
		newest.phase = modelAcc[AccWidth-1 -: PhaseWidth];
		expected = history[PipeLatency-1];
		for (int i = PipeLatency - 1; i > 0; i--)
		begin
			history[i] = history[i-1];
		end
		history[0] = newest;
	endtask

	// Drives one cycle just after an edge, then checks the output of the next edge.
	task automatic runCycle(input logic load, input logic en, input logic [AccWidth-1:0] value);
		phaseSample_t expected;
		cfg.load = load;
		cfg.enable = en;
		cfg.word = value;
		@(posedge Clock);
		#1;
		advanceModel(load, en, value, expected);
		checkEqual(phase.phase, expected.phase, "phase value");
		checkEqual(phase.wrap, expected.wrap, "wrap flag");
		checkEqual(phaseAccumTop_inst.accumChecker.failCount, 0, "bound assertion failures");
	endtask

	// Stops a run that takes longer than the table allows.
	always @(posedge Clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout: the test did not finish within %0d cycles.", cycleLimit);
			$display("STATUS: FAIL");
			$fatal(1, "Simulation ran past its cycle limit.");
		end
	end

	initial
	begin
		logic [AccWidth-1:0] value;
		Clock = 1'b0;
		reset = 1'b1;
		cfg = '0;
		modelWord = '0;
		modelEnable = 1'b0;
		modelAcc = '0;
		lfsrState = 32'h3924;
		cycleCount = 0;
		for (int i = 0; i < PipeLatency; i++)
		begin
			history[i] = '0;
		end
		cycleLimit = ResetCycles + PipeLatency + 20;
		for (int r = 0; r < NumRows; r++)
		begin
			cycleLimit += stimTable[r].holdCycles;
		end

		repeat (ResetCycles) @(posedge Clock);
		#1;
		reset = 1'b0;

		for (int r = 0; r < NumRows; r++)
		begin
			for (int c = 0; c < stimTable[r].holdCycles; c++)
			begin
				if (stimTable[r].randomWord)
				begin
					drawRandomWord(value);
					runCycle(1'b1, stimTable[r].enable, value);
				end
				else
				begin
					runCycle(c == 0, stimTable[r].enable, stimTable[r].word);
				end
			end
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- filelist.f
src/accumGeomPkg.sv
src/accumTypesPkg.sv
src/tuningWordReg.sv
src/laneSkew.sv
src/sliceCarryChain.sv
src/sumDeskew.sv
src/phaseAccumTop.sv
test/phaseAccum_checker.sv
test/phaseAccumTb.sv

//--- Bender.yml
package:
  name: phase_accum

sources:
  - files:
      - src/accumGeomPkg.sv
      - src/accumTypesPkg.sv
      - src/tuningWordReg.sv
      - src/laneSkew.sv
      - src/sliceCarryChain.sv
      - src/sumDeskew.sv
      - src/phaseAccumTop.sv
  - target: test
    files:
      - test/phaseAccum_checker.sv
      - test/phaseAccumTb.sv
